/* nnPkg.sv */
`default_nettype none

package nnPkg;

	localparam int DataWidth = 8;
	localparam int AccWidth = 20; // holds 30 full-scale products plus the bias.
	localparam int PixelCount = 30;
	localparam int HiddenCount = 6;
	localparam int ClassCount = 4;
	localparam int ClassIdWidth = 2;
	localparam int LayerLatency = 3; // capture, sum and activation stages of a node.

	// Layer selector 0 picks the hidden tables, any other value the output tables.
	localparam logic signed [DataWidth-1:0] HiddenWeights [HiddenCount][PixelCount] = '{
		'{
			8'sd12, -8'sd5, 8'sd33, 8'sd8, -8'sd17, 8'sd25,
			8'sd4, -8'sd9, 8'sd40, 8'sd14, -8'sd22, 8'sd6,
			8'sd19, -8'sd31, 8'sd2, 8'sd27, -8'sd8, 8'sd11,
			-8'sd3, 8'sd36, -8'sd14, 8'sd9, 8'sd21, -8'sd26,
			8'sd5, 8'sd17, -8'sd11, 8'sd30, -8'sd6, 8'sd13
		},
		'{
			-8'sd18, 8'sd24, -8'sd7, 8'sd15, 8'sd29, -8'sd12,
			8'sd3, 8'sd38, -8'sd25, 8'sd10, 8'sd7, -8'sd33,
			8'sd16, 8'sd22, -8'sd4, -8'sd9, 8'sd41, -8'sd15,
			8'sd26, 8'sd1, 8'sd18, -8'sd21, -8'sd2, 8'sd34,
			8'sd12, -8'sd28, 8'sd9, 8'sd5, 8'sd23, -8'sd10
		},
		'{
			8'sd31, 8'sd6, -8'sd14, -8'sd27, 8'sd11, 8'sd19,
			-8'sd36, 8'sd8, 8'sd2, 8'sd25, -8'sd13, 8'sd17,
			-8'sd20, 8'sd4, 8'sd37, 8'sd10, -8'sd5, -8'sd24,
			8'sd14, 8'sd28, -8'sd9, 8'sd32, -8'sd16, 8'sd7,
			-8'sd30, 8'sd21, 8'sd3, -8'sd12, 8'sd18, 8'sd26
		},
		'{
			-8'sd9, -8'sd21, 8'sd28, 8'sd5, 8'sd16, -8'sd34,
			8'sd22, 8'sd13, -8'sd7, -8'sd18, 8'sd30, 8'sd9,
			8'sd24, -8'sd11, 8'sd6, -8'sd25, 8'sd15, 8'sd35,
			-8'sd3, -8'sd16, 8'sd20, 8'sd4, 8'sd27, -8'sd8,
			8'sd19, -8'sd2, -8'sd29, 8'sd12, 8'sd33, -8'sd14
		},
		'{
			8'sd7, 8'sd35, 8'sd10, -8'sd19, -8'sd8, 8'sd23,
			8'sd14, -8'sd28, 8'sd17, 8'sd3, 8'sd26, -8'sd6,
			-8'sd15, 8'sd29, 8'sd21, -8'sd4, -8'sd23, 8'sd9,
			8'sd32, -8'sd13, 8'sd1, 8'sd24, -8'sd10, 8'sd16,
			-8'sd35, 8'sd8, 8'sd27, -8'sd17, 8'sd5, 8'sd20
		},
		'{
			8'sd20, -8'sd13, -8'sd26, 8'sd32, 8'sd4, 8'sd9,
			-8'sd17, 8'sd25, 8'sd11, -8'sd30, 8'sd2, 8'sd36,
			-8'sd8, 8'sd18, -8'sd22, 8'sd14, 8'sd7, -8'sd1,
			-8'sd19, 8'sd27, 8'sd12, -8'sd35, 8'sd6, 8'sd21,
			8'sd15, -8'sd5, 8'sd38, -8'sd24, -8'sd11, 8'sd3
		}
	};

	localparam logic signed [DataWidth-1:0] HiddenBias [HiddenCount] = '{
		8'sd10, -8'sd6, 8'sd15, -8'sd12, 8'sd4, 8'sd8
	};

	localparam logic signed [DataWidth-1:0] OutWeights [ClassCount][HiddenCount] = '{
		'{8'sd25, -8'sd18, 8'sd30, 8'sd12, -8'sd22, 8'sd9},
		'{-8'sd14, 8'sd28, -8'sd9, 8'sd20, 8'sd16, -8'sd25},
		'{8'sd19, 8'sd11, -8'sd27, -8'sd15, 8'sd31, 8'sd14},
		'{-8'sd21, 8'sd7, 8'sd17, 8'sd26, -8'sd12, 8'sd22}
	};

	localparam logic signed [DataWidth-1:0] OutBias [ClassCount] = '{
		8'sd5, -8'sd3, 8'sd8, 8'sd2
	};

	function automatic logic signed [DataWidth-1:0] weightOf(
		input int layerSel,
		input int nodeIdx,
		input int inIdx
	);
		if (layerSel == 0)
		begin
			return HiddenWeights[nodeIdx][inIdx];
		end
		return OutWeights[nodeIdx][inIdx];
	endfunction

	function automatic logic signed [DataWidth-1:0] biasOf(
		input int layerSel,
		input int nodeIdx
	);
		if (layerSel == 0)
		begin
			return HiddenBias[nodeIdx];
		end
		return OutBias[nodeIdx];
	endfunction

endpackage

`default_nettype wire

/* neuronNode.sv */
`timescale 1ns/1ns
`default_nettype none

module neuronNode #(
	parameter int LayerSel = 0,
	parameter int NodeIndex = 0,
	parameter int InCount = nnPkg::PixelCount,
	parameter int ActShift = 4
)
(
	input logic clk,
	input logic reset,
	input logic signed [nnPkg::DataWidth-1:0] actIn [InCount],
	output logic [nnPkg::DataWidth-1:0] actOut
);

	import nnPkg::*;

	localparam int MaxAct = 2 ** (DataWidth - 1) - 1;

	logic signed [DataWidth-1:0] actReg [InCount];
	logic signed [AccWidth-1:0] sumNext;
	logic signed [AccWidth-1:0] sumReg;
	logic signed [AccWidth-1:0] scaled;

	generate
		if (ActShift < 0 || ActShift > DataWidth)
		begin : gBadShift
			$error("neuronNode: ActShift %0d is outside 0 to %0d.", ActShift, DataWidth);
		end
	endgenerate

	// weights and bias fold to constants, so each product is a constant multiply.
	always_comb
	begin
		sumNext = AccWidth'(biasOf(LayerSel, NodeIndex));
		for (int i = 0; i < InCount; i++)
		begin
			sumNext = sumNext + AccWidth'(actReg[i] * weightOf(LayerSel, NodeIndex, i));
		end
	end

	assign scaled = sumReg >>> ActShift; // requantize toward the next layer's range.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '{default: '0};
			sumReg <= '0;
			actOut <= '0;
		end
		else
		begin
			actReg <= actIn;
			sumReg <= sumNext;
			if (sumReg[AccWidth-1])
			begin
				actOut <= '0; // relu clamps every negative sum.
			end
			else if (scaled > MaxAct)
			begin
				actOut <= DataWidth'(MaxAct);
			end
			else
			begin
				actOut <= scaled[DataWidth-1:0];
			end
		end
	end

endmodule

`default_nettype wire

/* denseLayer.sv */
`timescale 1ns/1ns
`default_nettype none

module denseLayer #(
	parameter int LayerSel = 0,
	parameter int InCount = nnPkg::PixelCount,
	parameter int NodeCount = nnPkg::HiddenCount,
	parameter int ActShift = 4
)
(
	input logic clk,
	input logic reset,
	input logic signed [nnPkg::DataWidth-1:0] actIn [InCount],
	input logic inValid,
	output logic signed [nnPkg::DataWidth-1:0] actOut [NodeCount],
	output logic outValid
);

	import nnPkg::*;

	logic [LayerLatency-1:0] validPipe;

	generate
		for (genvar n = 0; n < NodeCount; n++)
		begin : gNode
			neuronNode #(
				.LayerSel(LayerSel),
				.NodeIndex(n),
				.InCount(InCount),
				.ActShift(ActShift)
			) uNode (
				.clk(clk),
				.reset(reset),
				.actIn(actIn),
				.actOut(actOut[n])
			);
		end
	endgenerate

	// one stage per node register so the flag lines up with actOut.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[LayerLatency-2:0], inValid};
		end
	end

	assign outValid = validPipe[LayerLatency-1];

endmodule

`default_nettype wire

/* classArgmax.sv */
`timescale 1ns/1ns
`default_nettype none

module classArgmax #(
	parameter int Count = nnPkg::ClassCount
)
(
	input logic clk,
	input logic reset,
	input logic signed [nnPkg::DataWidth-1:0] scoreIn [Count],
	input logic inValid,
	output logic [nnPkg::ClassIdWidth-1:0] classOut,
	output logic outValid
);

	import nnPkg::*;

	logic [ClassIdWidth-1:0] bestIdx;
	logic signed [DataWidth-1:0] bestScore;

	generate
		if (Count > 2 ** ClassIdWidth)
		begin : gBadCount
			$error("classArgmax: %0d classes do not fit in %0d bits.", Count, ClassIdWidth);
		end
	endgenerate

	always_comb
	begin
		bestIdx = '0;
		bestScore = scoreIn[0];
		for (int i = 1; i < Count; i++)
		begin
			if (scoreIn[i] > bestScore) // strict compare keeps the lower index on a tie.
			begin
				bestIdx = ClassIdWidth'(i);
				bestScore = scoreIn[i];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classOut <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			classOut <= bestIdx;
			outValid <= inValid;
		end
	end

endmodule

`default_nettype wire

/* nnClassifier.sv */
`timescale 1ns/1ns
`default_nettype none

module nnClassifier #(
	parameter int HiddenShift = 4,
	parameter int OutShift = 3
)
(
	input logic clk,
	input logic reset,
	input logic signed [nnPkg::DataWidth-1:0] pixelIn [nnPkg::PixelCount],
	input logic inValid,
	output logic signed [nnPkg::DataWidth-1:0] scoreOut [nnPkg::ClassCount],
	output logic [nnPkg::ClassIdWidth-1:0] classOut,
	output logic outValid
);

	import nnPkg::*;

	logic signed [DataWidth-1:0] hiddenAct [HiddenCount];
	logic hiddenValid;
	logic scoreValid;

	denseLayer #(
		.LayerSel(0),
		.InCount(PixelCount),
		.NodeCount(HiddenCount),
		.ActShift(HiddenShift)
	) uHidden (
		.clk(clk),
		.reset(reset),
		.actIn(pixelIn),
		.inValid(inValid),
		.actOut(hiddenAct),
		.outValid(hiddenValid)
	);

	denseLayer #(
		.LayerSel(1),
		.InCount(HiddenCount),
		.NodeCount(ClassCount),
		.ActShift(OutShift)
	) uOutput (
		.clk(clk),
		.reset(reset),
		.actIn(hiddenAct),
		.inValid(hiddenValid),
		.actOut(scoreOut),
		.outValid(scoreValid)
	);

	// scores stay on scoreOut while the winner is registered one cycle later.
	classArgmax #(
		.Count(ClassCount)
	) uArgmax (
		.clk(clk),
		.reset(reset),
		.scoreIn(scoreOut),
		.inValid(scoreValid),
		.classOut(classOut),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

/* nnClassifier_props.sv */
`timescale 1ns/1ns
`default_nettype none

module nnClassifier_props (
	input logic clk,
	input logic reset,
	input logic inValid,
	input logic signed [nnPkg::DataWidth-1:0] scoreOut [nnPkg::ClassCount],
	input logic outValid,
	input logic [nnPkg::ClassIdWidth-1:0] classOut
);

	import nnPkg::*;

	logic [3:0] cleanCycles = '0; // edges since the last reset, stops at 7.
	logic signed [DataWidth-1:0] lastScore [ClassCount]; // scores behind the current classOut.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cleanCycles <= '0;
			lastScore <= '{default: '0};
		end
		else
		begin
			lastScore <= scoreOut;
			if (cleanCycles < 4'd7)
			begin
				cleanCycles <= cleanCycles + 4'd1;
			end
		end
	end

	validLatency: assert property (@(posedge clk)
		(cleanCycles >= 4'd7) |-> (outValid == $past(inValid, 7)))
		else $error("outValid does not follow inValid by seven cycles.");

	quietAfterReset: assert property (@(posedge clk) reset |=> !outValid)
		else $error("outValid is high in the cycle after reset.");

	// the winner beats every lower index and ties or beats every higher one.
	generate
		for (genvar c = 0; c < ClassCount; c++)
		begin : gWinner
			classIsWinner: assert property (@(posedge clk) outValid |->
				((int'(classOut) < ClassCount) &&
				((c < int'(classOut)) ? (lastScore[c] < lastScore[classOut])
					: (lastScore[c] <= lastScore[classOut]))))
				else $error("classOut %0d is not the lowest index of the top score.", classOut);
		end
	endgenerate

endmodule

bind nnClassifier nnClassifier_props uProps (
	.clk(clk),
	.reset(reset),
	.inValid(inValid),
	.scoreOut(scoreOut),
	.outValid(outValid),
	.classOut(classOut)
);

`default_nettype wire

/* nnClassifier_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module nnClassifier_tb;

	import nnPkg::*;

	localparam int HiddenShift = 4;
	localparam int OutShift = 3;
	localparam logic [31:0] Seed = 32'h4cd4_abb0;

	logic clk;
	logic reset;
	logic inValid;
	logic signed [DataWidth-1:0] pixelIn [PixelCount];
	logic signed [DataWidth-1:0] scoreOut [ClassCount];
	logic [ClassIdWidth-1:0] classOut;
	logic outValid;

	logic signed [DataWidth-1:0] stimVec [PixelCount];
	logic signed [DataWidth-1:0] prevScore [ClassCount];
	logic signed [DataWidth-1:0] expScoreQ [$];
	logic [ClassIdWidth-1:0] expClassQ [$];

	int errors = 0;
	int checks = 0;
	int expectedPulses = 0;
	int seenPulses = 0;

	nnClassifier #(
		.HiddenShift(HiddenShift),
		.OutShift(OutShift)
	) UUT (
		.clk(clk),
		.reset(reset),
		.pixelIn(pixelIn),
		.inValid(inValid),
		.scoreOut(scoreOut),
		.classOut(classOut),
		.outValid(outValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// relu, arithmetic shift, then clamp at the largest positive activation.
	function automatic logic signed [DataWidth-1:0] requant(input int sum, input int shift);
		int scaled;
		if (sum < 0)
		begin
			return '0;
		end
		scaled = sum >>> shift;
		if (scaled > 127)
		begin
			return 8'sd127;
		end
		return DataWidth'(scaled);
	endfunction

	function automatic void refClassify(
		input logic signed [DataWidth-1:0] pix [PixelCount],
		output logic signed [DataWidth-1:0] scores [ClassCount],
		output logic [ClassIdWidth-1:0] cls
	);
		logic signed [DataWidth-1:0] hidden [HiddenCount];
		int sum;
		int best;
		for (int n = 0; n < HiddenCount; n++)
		begin
			sum = int'(biasOf(0, n));
			for (int i = 0; i < PixelCount; i++)
			begin
				sum += int'(pix[i]) * int'(weightOf(0, n, i));
			end
			hidden[n] = requant(sum, HiddenShift);
		end
		for (int c = 0; c < ClassCount; c++)
		begin
			sum = int'(biasOf(1, c));
			for (int n = 0; n < HiddenCount; n++)
			begin
				sum += int'(hidden[n]) * int'(weightOf(1, c, n));
			end
			scores[c] = requant(sum, OutShift);
		end
		best = 0;
		for (int c = 1; c < ClassCount; c++)
		begin
			if (scores[c] > scores[best])
			begin
				best = c; // lowest index keeps a tie.
			end
		end
		cls = ClassIdWidth'(best);
	endfunction

	function automatic logic hasTopTie(input logic signed [DataWidth-1:0] scores [ClassCount]);
		logic signed [DataWidth-1:0] top;
		int hits;
		top = scores[0];
		hits = 0;
		for (int c = 1; c < ClassCount; c++)
		begin
			if (scores[c] > top)
			begin
				top = scores[c];
			end
		end
		for (int c = 0; c < ClassCount; c++)
		begin
			if (scores[c] == top)
			begin
				hits++;
			end
		end
		return hits > 1;
	endfunction

	task automatic randomizeVector();
		for (int i = 0; i < PixelCount; i++)
		begin
			stimVec[i] = DataWidth'($urandom);
		end
	endtask

	task automatic fillVector(input logic signed [DataWidth-1:0] value);
		for (int i = 0; i < PixelCount; i++)
		begin
			stimVec[i] = value;
		end
	endtask

	task automatic sendSample(input logic signed [DataWidth-1:0] pix [PixelCount], input logic valid);
		logic signed [DataWidth-1:0] scores [ClassCount];
		logic [ClassIdWidth-1:0] cls;
		@(posedge clk);
		#1;
		pixelIn = pix;
		inValid = valid;
		if (valid)
		begin
			refClassify(pix, scores, cls);
			for (int c = 0; c < ClassCount; c++)
			begin
				expScoreQ.push_back(scores[c]);
			end
			expClassQ.push_back(cls);
			expectedPulses++;
		end
	endtask

	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		@(posedge clk);
		#1;
		inValid = 1'b0;
		while (expClassQ.size() != 0 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (expClassQ.size() != 0)
		begin
			$display("Timeout: %0d results never appeared within %0d cycles.", expClassQ.size(), limit);
			errors++;
			expClassQ.delete();
			expScoreQ.delete();
		end
		repeat (10) @(posedge clk); // any stray outValid here is caught by the compare.
	endtask

	// scoreOut leads outValid by one cycle, so the compare uses last cycle's copy.
	always @(negedge clk)
	begin
		if (outValid)
		begin
			if (expClassQ.size() == 0)
			begin
				$display("Unexpected outValid at %0t with no sample outstanding.", $time);
				errors++;
			end
			else
			begin
				for (int c = 0; c < ClassCount; c++)
				begin
					logic signed [DataWidth-1:0] expScore;
					expScore = expScoreQ.pop_front();
					checks++;
					if (prevScore[c] != expScore)
					begin
						$display("Fail at %0t: sample %0d score %0d is %0d, expected %0d.",
							$time, seenPulses, c, prevScore[c], expScore);
						errors++;
					end
				end
				checks++;
				if (classOut != expClassQ[0])
				begin
					$display("Fail at %0t: sample %0d class is %0d, expected %0d.",
						$time, seenPulses, classOut, expClassQ[0]);
					errors++;
				end
				void'(expClassQ.pop_front());
			end
			seenPulses++;
		end
		prevScore = scoreOut;
	end

	initial
	begin
		int found;
		int flushed;
		logic signed [DataWidth-1:0] trialScores [ClassCount];
		logic [ClassIdWidth-1:0] trialClass;
		void'($urandom(Seed));
		reset = 1'b1;
		inValid = 1'b0;
		for (int i = 0; i < PixelCount; i++)
		begin
			pixelIn[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		fillVector('0); // bias only path.
		sendSample(stimVec, 1'b1);
		waitDrain(30);

		for (int k = 0; k < 200; k++)
		begin
			randomizeVector();
			sendSample(stimVec, 1'b1);
		end
		waitDrain(30);

		for (int k = 0; k < 150; k++)
		begin
			randomizeVector();
			sendSample(stimVec, ($urandom % 3) != 0);
		end
		waitDrain(30);

		fillVector(8'sd127);
		sendSample(stimVec, 1'b1);
		fillVector(8'h80);
		sendSample(stimVec, 1'b1);
		for (int i = 0; i < PixelCount; i++)
		begin
			stimVec[i] = (i % 2 == 0) ? 8'sd127 : 8'h80;
		end
		sendSample(stimVec, 1'b1);
		waitDrain(30);

		// full-range vectors drive most nodes into 0 or 127, so top ties show up often.
		found = 0;
		for (int k = 0; k < 3000 && found < 12; k++)
		begin
			randomizeVector();
			refClassify(stimVec, trialScores, trialClass);
			if (hasTopTie(trialScores))
			begin
				sendSample(stimVec, 1'b1);
				found++;
			end
		end
		if (found == 0)
		begin
			$display("The tie search found no input with two equal top scores.");
			errors++;
		end
		waitDrain(30);

		for (int k = 0; k < 5; k++)
		begin
			randomizeVector();
			sendSample(stimVec, 1'b1);
		end
		@(posedge clk);
		#1;
		inValid = 1'b0;
		reset = 1'b1;
		@(posedge clk);
		#1;
		flushed = expClassQ.size(); // these samples die in the cleared pipeline.
		expectedPulses -= flushed;
		expClassQ.delete();
		expScoreQ.delete();
		@(posedge clk);
		#1;
		reset = 1'b0;
		repeat (12) @(posedge clk);
		for (int k = 0; k < 10; k++)
		begin
			randomizeVector();
			sendSample(stimVec, 1'b1);
		end
		waitDrain(30);

		checks++;
		if (seenPulses != expectedPulses)
		begin
			$display("Fail at %0t: saw %0d outValid pulses, expected %0d.",
				$time, seenPulses, expectedPulses);
			errors++;
		end
		$display("errors: %0d, checks: %0d, samples: %0d", errors, checks, seenPulses);
		if (errors == 0)
		begin
			$display("TEST RESULT: PASS");
		end
		else
		begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
nnPkg.sv
neuronNode.sv
denseLayer.sv
classArgmax.sv
nnClassifier.sv
nnClassifier_props.sv
nnClassifier_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module nnClassifier_tb -o simv

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
